/* src/cubic_coe.mem */
// one row per phase 0 to 31, signed Q2.8 taps, 256 is 1.0
// fields c3_c2_c1_c0, c0 in the low 10 bits
0000000000_0000000000_0100000000_0000000000
0000000000_0000000100_0100000000_1111111100
0000000000_0000001010_0011111101_1111111001
1111111111_0000010000_0011111011_1111110110
1111111110_0000010111_0011110111_1111110100
1111111101_0000011111_0011110010_1111110010
1111111100_0000100111_0011101101_1111110000
1111111011_0000110000_0011100110_1111101111
1111111010_0000111010_0011011110_1111101110
1111111001_0001000100_0011010110_1111101101
1111110111_0001001110_0011001110_1111101101
1111110110_0001011001_0011000100_1111101101
1111110101_0001100100_0010111010_1111101101
1111110011_0001101111_0010110000_1111101110
1111110010_0001111010_0010100110_1111101110
1111110001_0010000101_0010011011_1111101111
1111110000_0010010000_0010010000_1111110000
1111101111_0010011011_0010000101_1111110001
1111101110_0010100110_0001111010_1111110010
1111101110_0010110000_0001101111_1111110011
1111101101_0010111010_0001100100_1111110101
1111101101_0011000100_0001011001_1111110110
1111101101_0011001101_0001001111_1111110111
1111101101_0011010110_0001000100_1111111001
1111101110_0011011110_0000111010_1111111010
1111101111_0011100101_0000110001_1111111011
1111110000_0011101100_0000101000_1111111100
1111110010_0011110010_0000011111_1111111101
1111110100_0011110111_0000010111_1111111110
1111110110_0011111011_0000010000_1111111111
1111111001_0011111110_0000001001_0000000000
1111111100_0011111111_0000000101_0000000000

/* src/scaler_coe_pkg.sv */
//--------------------------------------------------
// coefficient types: phase, single tap weight and
// the four-tap set read from the ROM
//--------------------------------------------------
`include "scaler_defs.svh"

package scaler_coe_pkg;

    // interpolation phase, fraction of the target in 1/32
    typedef logic [`SCALER_PHASE_W-1:0] phase_t;

    // signed weight, 256 is 1.0
    typedef logic signed [`SCALER_COE_W-1:0] coe_t;

    // c0 sits in the low bits, same as a .mem row
    typedef struct packed {
        coe_t c3;
        coe_t c2;
        coe_t c1;
        coe_t c0;
    } coe_set_t;

endpackage

/* src/scaler_ctrl.sv */
//--------------------------------------------------
// output position walker: latched step, input index
// and fixed-point target, emit and phase per pixel
//--------------------------------------------------
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line_start,
    input  logic [`SCALER_STEP_W-1:0] step,
    input  logic                      pix_valid,
    output logic                      emit,
    output scaler_coe_pkg::phase_t    phase
);

    // integer part of the position
    localparam int IDX_W = `SCALER_POS_W - `SCALER_PHASE_W;

    // 1.0 in fixed point
    localparam logic [`SCALER_STEP_W-1:0] STEP_ONE = 1 << `SCALER_PHASE_W;
    localparam logic [`SCALER_POS_W-1:0]  POS_ONE  = 1 << `SCALER_PHASE_W;

    // window needs two pixels past the target
    localparam logic [IDX_W:0] LEAD = 2;

    logic [`SCALER_STEP_W-1:0] step_q;
    logic [IDX_W-1:0]          idx;
    logic [`SCALER_POS_W-1:0]  target;
    logic [IDX_W-1:0]          target_int;
    logic [IDX_W:0]            emit_idx;

    // --------------------------------------------------
    // emit decision
    // --------------------------------------------------
    assign target_int = target[`SCALER_POS_W-1:`SCALER_PHASE_W];

    // one extra bit so the +2 cannot wrap
    assign emit_idx = {1'b0, target_int} + LEAD;

    // fires on the pixel that completes the window
    assign emit  = pix_valid && ({1'b0, idx} == emit_idx);

    // fraction of the target picks the ROM row
    assign phase = target[`SCALER_PHASE_W-1:0];

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= STEP_ONE;
            idx    <= '0;
            target <= POS_ONE;
        end else if (line_start) begin
            // new line, restart at position 1.0
            step_q <= step;
            idx    <= '0;
            target <= POS_ONE;
        end else begin
            if (pix_valid) begin
                idx <= idx + 1'b1;
            end
            // step >= 1.0, so at most one output per pixel
            if (emit) begin
                target <= target + {{(`SCALER_POS_W - `SCALER_STEP_W){1'b0}}, step_q};
            end
        end
    end

    // lines longer than 4095 pixels would wrap idx

endmodule

/* src/scaler_defs.svh */
//--------------------------------------------------
// widths, tap count and phase count for the
// horizontal bicubic scaler
//--------------------------------------------------
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

// gray pixel and signed Q2.8 coefficient
`define SCALER_PIX_W    8
`define SCALER_COE_W    10
`define SCALER_COE_FRAC 8

// filter shape
`define SCALER_TAPS     4
`define SCALER_PHASE_W  5
`define SCALER_PHASES   32

// step in 1/32 pixel, position has 12 integer bits
`define SCALER_STEP_W   8
`define SCALER_POS_W    17

`endif

/* src/scaler_line.sv */
//--------------------------------------------------
// line scaler top: control, window, coefficient
// ROM and MAC
//--------------------------------------------------
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_line (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      line_start,
    input  logic [`SCALER_STEP_W-1:0] step,
    input  logic                      pix_valid,
    input  scaler_pix_pkg::pix_t      pix_in,
    output logic                      out_valid,
    output scaler_pix_pkg::pix_t      out_pix
);

    logic                     emit;
    scaler_coe_pkg::phase_t   phase;
    scaler_pix_pkg::pix_job_t job;
    logic                     job_valid;
    scaler_coe_pkg::coe_set_t coe;

    // --------------------------------------------------
    // which pixels produce an output, and at which phase
    // --------------------------------------------------
    scaler_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .step       (step),
        .pix_valid  (pix_valid),
        .emit       (emit),
        .phase      (phase)
    );

    // window capture, job registered on the same edge
    scaler_window u_window (
        .clk       (clk),
        .rst       (rst),
        .pix_valid (pix_valid),
        .pix_in    (pix_in),
        .emit      (emit),
        .phase     (phase),
        .job       (job),
        .job_valid (job_valid)
    );

    // weights one cycle after the job
    scaler_rom_coe u_rom (
        .clk   (clk),
        .phase (job.phase),
        .coe   (coe)
    );

    // window delayed inside to meet the ROM data
    scaler_mac u_mac (
        .clk       (clk),
        .rst       (rst),
        .job_valid (job_valid),
        .win       (job.win),
        .coe       (coe),
        .out_valid (out_valid),
        .out_pix   (out_pix)
    );

endmodule

/* src/scaler_mac.sv */
//--------------------------------------------------
// four-tap MAC: align with ROM, products, then sum,
// round and clamp to the pixel range
//--------------------------------------------------
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_mac (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     job_valid,
    input  scaler_pix_pkg::pix_win_t win,
    input  scaler_coe_pkg::coe_set_t coe,
    output logic                     out_valid,
    output scaler_pix_pkg::pix_t     out_pix
);

    // 9-bit signed pixel times 10-bit weight, plus growth for 4 terms
    localparam int PROD_W = `SCALER_PIX_W + 1 + `SCALER_COE_W;
    localparam int SUM_W  = PROD_W + 2;

    localparam logic signed [SUM_W-1:0] ROUND   = 1 <<< (`SCALER_COE_FRAC - 1);
    localparam logic signed [SUM_W-1:0] PIX_MAX = (1 << `SCALER_PIX_W) - 1;

    scaler_pix_pkg::pix_win_t   win_d;
    logic                       vld_d;
    logic signed [PROD_W-1:0]   prod [`SCALER_TAPS];
    logic                       vld_p;
    logic signed [SUM_W-1:0]    sum;
    logic signed [SUM_W-1:0]    shifted;

    // pixel is unsigned, so widen with a zero first
    function automatic logic signed [PROD_W-1:0] tap_mul(
        input scaler_pix_pkg::pix_t p,
        input scaler_coe_pkg::coe_t c
    );
        logic signed [`SCALER_PIX_W:0] ps;
        ps = signed'({1'b0, p});
        return ps * c;
    endfunction

    // --------------------------------------------------
    // stage 0, wait for ROM data
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        win_d <= win;
    end

    // --------------------------------------------------
    // stage 1, products
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        prod[0] <= tap_mul(win_d.p0, coe.c0);
        prod[1] <= tap_mul(win_d.p1, coe.c1);
        prod[2] <= tap_mul(win_d.p2, coe.c2);
        prod[3] <= tap_mul(win_d.p3, coe.c3);
    end

    // --------------------------------------------------
    // stage 2, sum, round, clamp
    // --------------------------------------------------
    assign sum     = prod[0] + prod[1] + prod[2] + prod[3] + ROUND;
    assign shifted = sum >>> `SCALER_COE_FRAC;

    always_ff @(posedge clk) begin
        if (shifted < 0) begin
            out_pix <= '0;
        end else if (shifted > PIX_MAX) begin
            out_pix <= '1;
        end else begin
            out_pix <= shifted[`SCALER_PIX_W-1:0];
        end
    end

    // valid follows the data stages
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_d     <= 1'b0;
            vld_p     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            vld_d     <= job_valid;
            vld_p     <= vld_d;
            out_valid <= vld_p;
        end
    end

endmodule

/* src/scaler_pix_pkg.sv */
//--------------------------------------------------
// pixel types: single pixel, four-pixel window and
// the job handed from the window stage to the MAC
//--------------------------------------------------
`include "scaler_defs.svh"

package scaler_pix_pkg;

    // unsigned gray sample
    typedef logic [`SCALER_PIX_W-1:0] pix_t;

    // p0 oldest, p3 newest
    // p0 in the low bits, lined up with c0
    typedef struct packed {
        pix_t p3;
        pix_t p2;
        pix_t p1;
        pix_t p0;
    } pix_win_t;

    // window plus its phase
    typedef struct packed {
        pix_win_t               win;
        scaler_coe_pkg::phase_t phase;
    } pix_job_t;

endpackage

/* src/scaler_rom_coe.sv */
//--------------------------------------------------
// coefficient ROM, one four-tap set per phase,
// single registered read port
//--------------------------------------------------
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_rom_coe (
    input  logic                     clk,
    input  scaler_coe_pkg::phase_t   phase,
    output scaler_coe_pkg::coe_set_t coe
);

    localparam int SET_W = `SCALER_TAPS * `SCALER_COE_W;

    // one row per phase, taps side by side in columns
    logic [SET_W-1:0] rom [`SCALER_PHASES];

    // binary rows, c0 in the low 10 bits
    initial begin
        $readmemb("src/cubic_coe.mem", rom);
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    // address sampled on this edge, data valid after it
    always_ff @(posedge clk) begin
        coe <= scaler_coe_pkg::coe_set_t'(rom[phase]);
    end

endmodule

/* src/scaler_window.sv */
//--------------------------------------------------
// four-pixel shift window and registered job stage
//--------------------------------------------------
`timescale 1ns/1ps

module scaler_window (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pix_valid,
    input  scaler_pix_pkg::pix_t      pix_in,
    input  logic                      emit,
    input  scaler_coe_pkg::phase_t    phase,
    output scaler_pix_pkg::pix_job_t  job,
    output logic                      job_valid
);

    scaler_pix_pkg::pix_win_t win_q;
    scaler_pix_pkg::pix_win_t win_next;

    // window as it looks after this pixel shifts in
    always_comb begin
        win_next.p0 = win_q.p1;
        win_next.p1 = win_q.p2;
        win_next.p2 = win_q.p3;
        win_next.p3 = pix_in;
    end

    // shift only on a strobe, gaps hold the window
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            win_q <= win_next;
        end
    end

    // --------------------------------------------------
    // job stage
    // --------------------------------------------------
    // pipeline timing starts here
    always_ff @(posedge clk) begin
        if (pix_valid && emit) begin
            job.win   <= win_next;
            job.phase <= phase;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= pix_valid && emit;
        end
    end

endmodule

/* tb.f */
+incdir+src
src/scaler_coe_pkg.sv
src/scaler_pix_pkg.sv
src/scaler_rom_coe.sv
src/scaler_ctrl.sv
src/scaler_window.sv
src/scaler_mac.sv
src/scaler_line.sv
verification/scaler_tb_clk.sv
verification/scaler_tb.sv

/* verification/scaler_tb.sv */
//--------------------------------------------------
// directed tests for the line scaler: reference
// model built on the coefficient table, output
// monitor and per-test result lines
//--------------------------------------------------
`timescale 1ns/1ps
`include "scaler_defs.svh"

module scaler_tb;

    localparam int TIMEOUT = 400;

    logic                      clk;
    logic                      rst;
    logic                      line_start;
    logic [`SCALER_STEP_W-1:0] step;
    logic                      pix_valid;
    scaler_pix_pkg::pix_t      pix_in;
    logic                      out_valid;
    scaler_pix_pkg::pix_t      out_pix;

    // model copy of the table, c0 in the low bits
    logic [`SCALER_TAPS*`SCALER_COE_W-1:0] coe_rom [`SCALER_PHASES];

    int pix_buf[$];
    int exp_q[$];
    int got_q[$];
    int err_count;
    int test_count;
    int fail_count;
    int start_errs;
    int seed;

    scaler_tb_clk u_clk (.clk(clk));

    scaler_line dut (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .step       (step),
        .pix_valid  (pix_valid),
        .pix_in     (pix_in),
        .out_valid  (out_valid),
        .out_pix    (out_pix)
    );

    // results sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            got_q.push_back(int'(out_pix));
        end
    end

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // window ends at pixel n, taps p0..p3 = n-3..n
    function automatic int filter_pixel(int n, int ph);
        int acc;
        int c;
        acc = 128;
        for (int t = 0; t < `SCALER_TAPS; t++) begin
            c = $signed(coe_rom[ph][t*`SCALER_COE_W +: `SCALER_COE_W]);
            acc += pix_buf[n - 3 + t] * c;
        end
        acc = acc >>> 8;
        if (acc < 0) return 0;
        if (acc > 255) return 255;
        return acc;
    endfunction

    // target starts at 1.0, emit when index hits int part + 2
    task automatic build_expected(int step_v);
        int target;
        target = 32;
        for (int n = 0; n < pix_buf.size(); n++) begin
            if (n == (target >> 5) + 2) begin
                exp_q.push_back(filter_pixel(n, target % 32));
                target += step_v;
            end
        end
    endtask

    task automatic fill_random(int len);
        pix_buf.delete();
        repeat (len) pix_buf.push_back($urandom % 256);
    endtask

    // --------------------------------------------------
    // stimulus and checking
    // --------------------------------------------------
    // line_start pulse, then the pixels with up to max_gap idle cycles
    task automatic drive_line(int step_v, int max_gap);
        int gap;
        line_start = 1'b1;
        step       = step_v[`SCALER_STEP_W-1:0];
        next_cycle();
        line_start = 1'b0;
        foreach (pix_buf[i]) begin
            pix_valid = 1'b1;
            pix_in    = scaler_pix_pkg::pix_t'(pix_buf[i]);
            next_cycle();
            pix_valid = 1'b0;
            gap = (max_gap > 0) ? $urandom % (max_gap + 1) : 0;
            repeat (gap) next_cycle();
        end
    endtask

    task automatic begin_test();
        got_q.delete();
        exp_q.delete();
        start_errs = err_count;
    endtask

    task automatic report_test(string name);
        test_count++;
        if (err_count == start_errs) begin
            $display("%s: pass, %0d outputs", name, exp_q.size());
        end else begin
            fail_count++;
            $display("%s: fail", name);
        end
    endtask

    task automatic finish_test(string name);
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        // pipeline is 4 edges deep, any extra result shows up by now
        repeat (6) next_cycle();
        if (got_q.size() < exp_q.size()) begin
            $display("%s: timed out, only %0d of %0d outputs arrived",
                     name, got_q.size(), exp_q.size());
            err_count++;
        end
        if (got_q.size() > exp_q.size()) begin
            $display("%s: got %0d outputs but only %0d were due",
                     name, got_q.size(), exp_q.size());
            err_count++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            if (got_q[i] != exp_q[i]) begin
                $display("Error %s: output %0d expected %0d actual %0d",
                         name, i, exp_q[i], got_q[i]);
                err_count++;
            end
        end
        report_test(name);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_idle();
        begin_test();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("idle: out_valid was not low with no line sent");
                err_count++;
            end
        end
        next_cycle();
        report_test("idle");
    endtask

    // row 0 passes p1 straight through
    task automatic test_unity();
        begin_test();
        pix_buf.delete();
        for (int i = 0; i < 16; i++) pix_buf.push_back(i * 16 + 3);
        for (int i = 0; i < 13; i++) exp_q.push_back(pix_buf[i + 1]);
        drive_line(32, 0);
        finish_test("unity_step");
    endtask

    // phases 0 and 16 alternate
    task automatic test_fraction();
        begin_test();
        fill_random(24);
        build_expected(48);
        drive_line(48, 3);
        finish_test("fraction_step");
    endtask

    // pairs of 0 and 255, lobes overshoot both ends
    task automatic test_clamp();
        begin_test();
        pix_buf.delete();
        for (int i = 0; i < 24; i++) pix_buf.push_back(((i / 2) % 2) ? 255 : 0);
        build_expected(40);
        drive_line(40, 0);
        finish_test("clamp");
    endtask

    // second line starts right behind the first, no flush
    task automatic test_two_lines();
        begin_test();
        fill_random(20);
        build_expected(64);
        drive_line(64, 0);
        fill_random(16);
        build_expected(32);
        drive_line(32, 0);
        finish_test("two_lines");
    endtask

    task automatic test_random_lines();
        int step_v;
        for (int l = 0; l < 3; l++) begin
            begin_test();
            fill_random(8 + $urandom % 33);
            step_v = 32 + $urandom % 224;
            build_expected(step_v);
            drive_line(step_v, 2);
            finish_test($sformatf("random_line_%0d", l));
        end
    endtask

    initial begin
        seed       = 2267;
        seed       = $urandom(seed);
        rst        = 1'b1;
        line_start = 1'b0;
        step       = 8'd32;
        pix_valid  = 1'b0;
        pix_in     = '0;
        err_count  = 0;
        test_count = 0;
        fail_count = 0;
        $readmemb("src/cubic_coe.mem", coe_rom);
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        test_idle();
        test_unity();
        test_fraction();
        test_clamp();
        test_two_lines();
        test_random_lines();
        $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verification/scaler_tb_clk.sv */
//--------------------------------------------------
// free-running testbench clock, 100 ns period
//--------------------------------------------------
`timescale 1ns/1ps

module scaler_tb_clk #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period low, half high
    always begin
        #(PERIOD / 2.0) clk = ~clk;
    end

endmodule
